// File: logic/pcie_qm_config.svh
`ifndef PCIE_QM_CONFIG_SVH
`define PCIE_QM_CONFIG_SVH

// number of packet queue managers, power of two
`define NB_PKT_QM 4

// log2 of the manager count
`define QM_ID_WIDTH 2

// total packet queues, spread evenly over the managers
`define NB_FLOWS 16

// log2 of the queue count
`define FLOW_ID_WIDTH 4

// ring slot index width
// pointers carry one extra bit so a ring of 2**RB_AWIDTH fits
`define RB_AWIDTH 4

// entries in the arrival order FIFO, power of two
`define ORDER_DEPTH 8

`endif

// File: logic/mmio_pkg.sv
`default_nettype none

`include "pcie_qm_config.svh"

package mmio_pkg;

    // control word at ctrl_addr
    typedef struct packed {
        logic [3:0]               rsvd_hi;
        logic                     soft_reset;
        logic [24-`RB_AWIDTH:0]   rsvd_mid;
        logic [`RB_AWIDTH:0]      rb_size;
        logic                     disable_qm;
    } mmio_ctrl_t;

    // head pointer word in a queue page
    typedef struct packed {
        logic [30-`RB_AWIDTH:0]   rsvd;
        logic [`RB_AWIDTH:0]      head;
    } mmio_ptr_t;

    // same write word, view chosen by the address
    typedef union packed {
        mmio_ctrl_t ctrl;
        mmio_ptr_t  ptr;
    } mmio_word_u;

    localparam logic [15:0] ctrl_addr       = 16'h0000;
    localparam logic [15:0] queue_page_base = 16'h1000;
    // one queue page every 16 bytes
    localparam int          queue_page_shift = 4;

endpackage

`default_nettype wire

// File: logic/queue_pkg.sv
`default_nettype none

`include "pcie_qm_config.svh"

package queue_pkg;

    // manager id, low bits of the queue id
    typedef logic [`QM_ID_WIDTH-1:0] qm_id_t;

    // queue index inside one manager, high bits of the queue id
    typedef logic [`FLOW_ID_WIDTH-`QM_ID_WIDTH-1:0] local_idx_t;

    // ring pointer, also used for ring size and slots
    typedef logic [`RB_AWIDTH:0] rb_ptr_t;

    typedef struct packed {
        logic [`FLOW_ID_WIDTH-1:0] pkt_queue_id;
        logic [15:0]               size;
    } pkt_meta_t;

    // record after the manager has given it a slot
    typedef struct packed {
        pkt_meta_t meta;
        rb_ptr_t   slot;
    } pkt_meta_slot_t;

endpackage

`default_nettype wire

// File: logic/mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_qm_config.svh"

module mmio_regs
    import mmio_pkg::*;
    import queue_pkg::*;
(
    input  wire logic                 pcie_clk,
    input  wire logic                 rst_n,
    input  wire logic [15:0]          mmio_address,
    input  wire logic                 mmio_write,
    input  wire logic                 mmio_read,
    input  var  mmio_word_u           mmio_writedata,
    output logic [31:0]               mmio_readdata,
    output logic                      mmio_readdatavalid,
    output rb_ptr_t                   rb_size,
    output logic                      disable_qm,
    output logic                      sw_reset,
    output logic [`NB_PKT_QM-1:0]     head_upd,
    output local_idx_t                head_upd_idx,
    output rb_ptr_t                   head_upd_ptr
);

    mmio_word_u ctrl_q;

    logic [15:0]               page_off;
    logic                      queue_hit;
    logic [`FLOW_ID_WIDTH-1:0] queue_idx;
    qm_id_t                    owner_id;

    // control fields come straight from the stored word
    assign disable_qm = ctrl_q.ctrl.disable_qm;
    assign rb_size    = ctrl_q.ctrl.rb_size;
    // sw must clear this again itself
    assign sw_reset   = ctrl_q.ctrl.soft_reset;

    // addresses below the page base wrap to large offsets and miss
    assign page_off  = mmio_address - queue_page_base;
    assign queue_hit = mmio_write
                       && (page_off < 16'(`NB_FLOWS << queue_page_shift))
                       && (page_off[queue_page_shift-1:0] == '0);
    assign queue_idx = page_off[queue_page_shift +: `FLOW_ID_WIDTH];

    // low queue bits pick the owning manager
    assign owner_id = queue_idx[`QM_ID_WIDTH-1:0];

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q             <= '0;
            head_upd           <= '0;
            mmio_readdatavalid <= 1'b0;
        end else begin
            if (mmio_write && (mmio_address == ctrl_addr)) begin
                ctrl_q <= mmio_writedata;
            end
            head_upd <= '0;
            if (queue_hit) begin
                head_upd[owner_id] <= 1'b1;
            end
            mmio_readdatavalid <= mmio_read;
        end
    end

    // strobe payload, only looked at with head_upd
    always_ff @(posedge pcie_clk) begin
        if (queue_hit) begin
            head_upd_idx <= queue_idx[`FLOW_ID_WIDTH-1:`QM_ID_WIDTH];
            head_upd_ptr <= mmio_writedata.ptr.head;
        end
        if (mmio_read) begin
            if (mmio_address == ctrl_addr) begin
                mmio_readdata <= ctrl_q;
            end else begin
                mmio_readdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/meta_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_qm_config.svh"

module meta_dispatch
    import queue_pkg::*;
(
    input  wire logic                      in_valid,
    input  wire logic [`FLOW_ID_WIDTH-1:0] in_pkt_queue_id,
    input  wire logic [15:0]               in_size,
    input  wire logic [`NB_PKT_QM-1:0]     qm_in_ready,
    input  wire logic                      order_room,
    input  wire logic                      disable_qm,
    input  wire logic                      sw_reset,
    output logic                           in_ready,
    output logic [`NB_PKT_QM-1:0]          qm_in_valid,
    output pkt_meta_t                      qm_in_meta,
    output logic                           order_push,
    output qm_id_t                         order_id
);

    qm_id_t target;
    logic   path_open;

    // managers own queues by the low id bits
    assign target = in_pkt_queue_id[`QM_ID_WIDTH-1:0];

    // one shared record bus, only the target sees valid
    assign qm_in_meta.pkt_queue_id = in_pkt_queue_id;
    assign qm_in_meta.size         = in_size;

    // block closed by software or no space left to record the order
    assign path_open = !disable_qm && !sw_reset && order_room;

    assign in_ready = path_open && qm_in_ready[target];

    // valid does not wait on the manager ready
    always_comb begin
        for (int i = 0; i < `NB_PKT_QM; i++) begin
            qm_in_valid[i] = in_valid && path_open && (target == qm_id_t'(i));
        end
    end

    // every accepted record leaves its manager id behind
    assign order_push = in_valid && in_ready;
    assign order_id   = target;

endmodule

`default_nettype wire

// File: logic/pkt_queue_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_qm_config.svh"

module pkt_queue_manager
    import queue_pkg::*;
(
    input  wire logic      pcie_clk,
    input  wire logic      rst_n,
    input  wire logic      in_valid,
    input  var  pkt_meta_t in_meta,
    input  var  rb_ptr_t   rb_size,
    input  wire logic      sw_reset,
    input  wire logic      head_upd,
    input  var local_idx_t head_upd_idx,
    input  var  rb_ptr_t   head_upd_ptr,
    input  wire logic      out_ready,
    output logic           in_ready,
    output logic           out_valid,
    output pkt_meta_slot_t out_meta
);

    localparam int nb_queues = `NB_FLOWS / `NB_PKT_QM;

    rb_ptr_t tails [nb_queues];
    rb_ptr_t heads [nb_queues];

    local_idx_t in_idx;
    rb_ptr_t    cur_tail;
    rb_ptr_t    next_tail;
    logic       ring_full;
    logic       out_free;
    logic       accept;

    // low id bits already chose this manager
    assign in_idx   = in_meta.pkt_queue_id[`FLOW_ID_WIDTH-1:`QM_ID_WIDTH];
    assign cur_tail = tails[in_idx];

    // tail + 1 modulo ring size
    always_comb begin
        if ({1'b0, cur_tail} + 1'b1 >= {1'b0, rb_size}) begin
            next_tail = '0;
        end else begin
            next_tail = cur_tail + 1'b1;
        end
    end

    // one slot stays empty so full and empty differ
    // zero ring size means the ring is not set up yet
    assign ring_full = (rb_size == '0) || (next_tail == heads[in_idx]);

    assign out_free = !out_valid || out_ready;
    assign in_ready = out_free && !ring_full && !sw_reset;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < nb_queues; i++) begin
                tails[i] <= '0;
                heads[i] <= '0;
            end
        end else if (sw_reset) begin
            for (int i = 0; i < nb_queues; i++) begin
                tails[i] <= '0;
                heads[i] <= '0;
            end
        end else begin
            if (accept) begin
                tails[in_idx] <= next_tail;
            end
            // software consumed entries up to this head
            if (head_upd) begin
                heads[head_upd_idx] <= head_upd_ptr;
            end
        end
    end

    // single output register, one record in flight
    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (accept) begin
            out_meta.meta <= in_meta;
            // record gets the slot at the old tail
            out_meta.slot <= cur_tail;
        end
    end

endmodule

`default_nettype wire

// File: logic/ordered_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_qm_config.svh"

module ordered_merge
    import queue_pkg::*;
(
    input  wire logic                  pcie_clk,
    input  wire logic                  rst_n,
    input  wire logic                  order_push,
    input  var  qm_id_t                order_id,
    input  wire logic [`NB_PKT_QM-1:0] qm_out_valid,
    input  var  pkt_meta_slot_t        qm_out_meta [`NB_PKT_QM],
    input  wire logic                  out_ready,
    output logic                       order_room,
    output logic [`NB_PKT_QM-1:0]      qm_out_ready,
    output logic                       out_valid,
    output logic [`FLOW_ID_WIDTH-1:0]  out_pkt_queue_id,
    output logic [15:0]                out_size,
    output rb_ptr_t                    out_slot
);

    localparam int order_awidth = $clog2(`ORDER_DEPTH);

    qm_id_t                  order_mem [`ORDER_DEPTH];
    logic [order_awidth-1:0] wr_ptr;
    logic [order_awidth-1:0] rd_ptr;
    logic [order_awidth:0]   count;

    qm_id_t head_id;
    logic   order_valid;
    logic   pop;

    assign head_id     = order_mem[rd_ptr];
    assign order_valid = (count != '0);

    // room does not count on a pop in the same cycle
    assign order_room = (count != (order_awidth + 1)'(`ORDER_DEPTH));

    // only the oldest manager may drain
    assign out_valid = order_valid && qm_out_valid[head_id];

    always_comb begin
        for (int i = 0; i < `NB_PKT_QM; i++) begin
            qm_out_ready[i] = order_valid && (head_id == qm_id_t'(i)) && out_ready;
        end
    end

    assign out_pkt_queue_id = qm_out_meta[head_id].meta.pkt_queue_id;
    assign out_size         = qm_out_meta[head_id].meta.size;
    assign out_slot         = qm_out_meta[head_id].slot;

    assign pop = out_valid && out_ready;

    always_ff @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (order_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            if (order_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !order_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (order_push) begin
            order_mem[wr_ptr] <= order_id;
        end
    end

endmodule

`default_nettype wire

// File: logic/pcie_qm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_qm_config.svh"

module pcie_qm_top
    import queue_pkg::*;
(
    input  wire logic                      pcie_clk,
    input  wire logic                      rst_n,
    input  wire logic                      in_valid,
    input  wire logic [`FLOW_ID_WIDTH-1:0] in_pkt_queue_id,
    input  wire logic [15:0]               in_size,
    output logic                           in_ready,
    output logic                           out_valid,
    output logic [`FLOW_ID_WIDTH-1:0]      out_pkt_queue_id,
    output logic [15:0]                    out_size,
    output rb_ptr_t                        out_slot,
    input  wire logic                      out_ready,
    input  wire logic [15:0]               mmio_address,
    input  wire logic                      mmio_write,
    input  wire logic                      mmio_read,
    input  wire logic [31:0]               mmio_writedata,
    output logic [31:0]                    mmio_readdata,
    output logic                           mmio_readdatavalid
);

    rb_ptr_t                rb_size;
    logic                   disable_qm;
    logic                   sw_reset;
    logic [`NB_PKT_QM-1:0]  head_upd;
    local_idx_t             head_upd_idx;
    rb_ptr_t                head_upd_ptr;

    logic [`NB_PKT_QM-1:0]  qm_in_valid;
    logic [`NB_PKT_QM-1:0]  qm_in_ready;
    pkt_meta_t              qm_in_meta;
    logic [`NB_PKT_QM-1:0]  qm_out_valid;
    logic [`NB_PKT_QM-1:0]  qm_out_ready;
    pkt_meta_slot_t         qm_out_meta [`NB_PKT_QM];

    logic                   order_push;
    qm_id_t                 order_id;
    logic                   order_room;

    mmio_regs u_mmio_regs (
        .pcie_clk           (pcie_clk),
        .rst_n              (rst_n),
        .mmio_address       (mmio_address),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_writedata     (mmio_writedata),
        .mmio_readdata      (mmio_readdata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .rb_size            (rb_size),
        .disable_qm         (disable_qm),
        .sw_reset           (sw_reset),
        .head_upd           (head_upd),
        .head_upd_idx       (head_upd_idx),
        .head_upd_ptr       (head_upd_ptr)
    );

    meta_dispatch u_meta_dispatch (
        .in_valid        (in_valid),
        .in_pkt_queue_id (in_pkt_queue_id),
        .in_size         (in_size),
        .qm_in_ready     (qm_in_ready),
        .order_room      (order_room),
        .disable_qm      (disable_qm),
        .sw_reset        (sw_reset),
        .in_ready        (in_ready),
        .qm_in_valid     (qm_in_valid),
        .qm_in_meta      (qm_in_meta),
        .order_push      (order_push),
        .order_id        (order_id)
    );

    // one manager per group of queues sharing the low id bits
    for (genvar i = 0; i < `NB_PKT_QM; i++) begin : g_qm
        pkt_queue_manager u_pkt_queue_manager (
            .pcie_clk     (pcie_clk),
            .rst_n        (rst_n),
            .in_valid     (qm_in_valid[i]),
            .in_meta      (qm_in_meta),
            .rb_size      (rb_size),
            .sw_reset     (sw_reset),
            .head_upd     (head_upd[i]),
            .head_upd_idx (head_upd_idx),
            .head_upd_ptr (head_upd_ptr),
            .out_ready    (qm_out_ready[i]),
            .in_ready     (qm_in_ready[i]),
            .out_valid    (qm_out_valid[i]),
            .out_meta     (qm_out_meta[i])
        );
    end

    ordered_merge u_ordered_merge (
        .pcie_clk         (pcie_clk),
        .rst_n            (rst_n),
        .order_push       (order_push),
        .order_id         (order_id),
        .qm_out_valid     (qm_out_valid),
        .qm_out_meta      (qm_out_meta),
        .out_ready        (out_ready),
        .order_room       (order_room),
        .qm_out_ready     (qm_out_ready),
        .out_valid        (out_valid),
        .out_pkt_queue_id (out_pkt_queue_id),
        .out_size         (out_size),
        .out_slot         (out_slot)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real period_ns    = 40.0,
    parameter int  reset_cycles = 16
) (
    output logic pcie_clk,
    output logic rst_n
);

    initial begin
        pcie_clk = 1'b0;
        forever #(period_ns / 2.0) pcie_clk = ~pcie_clk;
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge pcie_clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/pcie_qm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcie_qm_config.svh"

module pcie_qm_tb;

    localparam int          stim_cycles = 1800;
    localparam logic [15:0] page_base   = 16'h1000;

    typedef logic [`RB_AWIDTH:0]       ptr_t;
    typedef logic [`FLOW_ID_WIDTH-1:0] qid_t;

    typedef struct packed {
        qid_t        qid;
        logic [15:0] size;
        ptr_t        slot;
    } rec_t;

    wire pcie_clk;
    wire rst_n;

    logic        in_valid;
    qid_t        in_pkt_queue_id;
    logic [15:0] in_size;
    logic        in_ready;
    logic        out_valid;
    qid_t        out_pkt_queue_id;
    logic [15:0] out_size;
    ptr_t        out_slot;
    logic        out_ready;
    logic [15:0] mmio_address;
    logic        mmio_write;
    logic        mmio_read;
    logic [31:0] mmio_writedata;
    logic [31:0] mmio_readdata;
    logic        mmio_readdatavalid;

    integer seed = 32'h3cf1;
    int     mismatch_errors = 0;
    int     other_errors = 0;

    // reference model state
    ptr_t        m_tails [`NB_FLOWS];
    ptr_t        m_heads [`NB_FLOWS];
    ptr_t        m_rb;
    logic        m_dis;
    logic        m_sw;
    logic [31:0] m_ctrl;
    logic        ctrl_written;
    logic        pend_valid;
    qid_t        pend_q;
    ptr_t        pend_ptr;
    logic        rd_pending;
    logic [31:0] rd_exp;
    rec_t        exp_q [$];
    logic        exp_valid;
    rec_t        exp_cur;
    logic        exp_full;

    // software side of the traffic phase
    ptr_t                              rb_cfg;
    logic [`FLOW_ID_WIDTH+`RB_AWIDTH:0] head_q [$];

    tb_clock clk_gen (
        .pcie_clk (pcie_clk),
        .rst_n    (rst_n)
    );

    pcie_qm_top dut0 (
        .pcie_clk           (pcie_clk),
        .rst_n              (rst_n),
        .in_valid           (in_valid),
        .in_pkt_queue_id    (in_pkt_queue_id),
        .in_size            (in_size),
        .in_ready           (in_ready),
        .out_valid          (out_valid),
        .out_pkt_queue_id   (out_pkt_queue_id),
        .out_size           (out_size),
        .out_slot           (out_slot),
        .out_ready          (out_ready),
        .mmio_address       (mmio_address),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_writedata     (mmio_writedata),
        .mmio_readdata      (mmio_readdata),
        .mmio_readdatavalid (mmio_readdatavalid)
    );

    // slot after t on a ring of rb entries
    function automatic ptr_t next_slot(input ptr_t t, input ptr_t rb);
        if (rb == '0) begin
            return '0;
        end
        return ptr_t'((int'(t) + 1) % int'(rb));
    endfunction

    function automatic logic [31:0] ctrl_word(input logic dis, input ptr_t rb, input logic srst);
        logic [31:0] w;
        w = '0;
        w[0] = dis;
        w[`RB_AWIDTH+1:1] = rb;
        w[27] = srst;
        return w;
    endfunction

    function automatic logic [15:0] queue_addr(input qid_t q);
        return page_base + 16'(q) * 16'd16;
    endfunction

    task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
        mismatch_errors++;
        $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
    endtask

    task report_failure(input string what);
        other_errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // ring is full when one more entry would meet the head
    assign exp_full = (m_rb == '0)
                      || (next_slot(m_tails[in_pkt_queue_id], m_rb) == m_heads[in_pkt_queue_id]);

    always @(posedge pcie_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NB_FLOWS; i++) begin
                m_tails[i] = '0;
                m_heads[i] = '0;
            end
            m_rb = '0;
            m_dis = 1'b0;
            m_sw = 1'b0;
            m_ctrl = '0;
            ctrl_written = 1'b0;
            pend_valid = 1'b0;
            rd_pending = 1'b0;
            rd_exp = '0;
            exp_q.delete();
            exp_valid = 1'b0;
        end else begin
            if (out_valid && out_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (in_valid && in_ready) begin
                exp_q.push_back('{qid: in_pkt_queue_id, size: in_size,
                                  slot: m_tails[in_pkt_queue_id]});
            end
            if (m_sw) begin
                for (int i = 0; i < `NB_FLOWS; i++) begin
                    m_tails[i] = '0;
                    m_heads[i] = '0;
                end
            end else begin
                if (in_valid && in_ready) begin
                    m_tails[in_pkt_queue_id] = next_slot(m_tails[in_pkt_queue_id], m_rb);
                end
                // head lands one edge after the write is seen
                if (pend_valid) begin
                    m_heads[pend_q] = pend_ptr;
                end
            end
            pend_valid = mmio_write && (mmio_address >= page_base)
                         && (mmio_address < page_base + 16'(`NB_FLOWS * 16))
                         && (mmio_address[3:0] == 4'h0);
            pend_q = qid_t'((mmio_address - page_base) >> 4);
            pend_ptr = mmio_writedata[`RB_AWIDTH:0];
            rd_pending = mmio_read;
            if (mmio_read) begin
                rd_exp = (mmio_address == 16'h0000) ? m_ctrl : 32'h0;
            end
            if (mmio_write && mmio_address == 16'h0000) begin
                m_ctrl = mmio_writedata;
                m_dis = mmio_writedata[0];
                m_rb = mmio_writedata[`RB_AWIDTH+1:1];
                m_sw = mmio_writedata[27];
                ctrl_written = 1'b1;
            end
            exp_valid = (exp_q.size() != 0);
            if (exp_valid) begin
                exp_cur = exp_q[0];
            end
        end
    end

    // quiet outputs until the first control write
    reset_in_ready: assert property (@(posedge pcie_clk) !ctrl_written |-> !in_ready)
        else report_mismatch("in_ready", $sampled(in_ready), 32'h0);
    reset_out_valid: assert property (@(posedge pcie_clk) !ctrl_written |-> !out_valid)
        else report_mismatch("out_valid", $sampled(out_valid), 32'h0);
    reset_rdv: assert property (@(posedge pcie_clk) !ctrl_written |-> !mmio_readdatavalid)
        else report_mismatch("mmio_readdatavalid", $sampled(mmio_readdatavalid), 32'h0);

    full_stall: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        in_valid && exp_full |-> !in_ready)
        else report_mismatch("in_ready", $sampled(in_ready), 32'h0);
    closed_stall: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        (m_dis || m_sw) |-> !in_ready)
        else report_mismatch("in_ready", $sampled(in_ready), 32'h0);

    out_outstanding: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        out_valid |-> exp_valid)
        else report_failure("out_valid high with no accepted record outstanding");
    out_qid: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        out_valid && exp_valid |-> out_pkt_queue_id == exp_cur.qid)
        else report_mismatch("out_pkt_queue_id", $sampled(out_pkt_queue_id),
                             $sampled(exp_cur.qid));
    out_sz: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        out_valid && exp_valid |-> out_size == exp_cur.size)
        else report_mismatch("out_size", $sampled(out_size), $sampled(exp_cur.size));
    out_sl: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        out_valid && exp_valid |-> out_slot == exp_cur.slot)
        else report_mismatch("out_slot", $sampled(out_slot), $sampled(exp_cur.slot));

    rd_timing: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        mmio_readdatavalid == rd_pending)
        else report_mismatch("mmio_readdatavalid", $sampled(mmio_readdatavalid),
                             $sampled(rd_pending));
    rd_data: assert property (@(posedge pcie_clk) disable iff (!rst_n)
        mmio_readdatavalid |-> mmio_readdata == rd_exp)
        else report_mismatch("mmio_readdata", $sampled(mmio_readdata), $sampled(rd_exp));

    task mmio_write_word(input logic [15:0] addr, input logic [31:0] data);
        @(posedge pcie_clk);
        mmio_write <= 1'b1;
        mmio_address <= addr;
        mmio_writedata <= data;
        @(posedge pcie_clk);
        mmio_write <= 1'b0;
    endtask

    task mmio_read_word(input logic [15:0] addr);
        @(posedge pcie_clk);
        mmio_read <= 1'b1;
        mmio_address <= addr;
        @(posedge pcie_clk);
        mmio_read <= 1'b0;
    endtask

    task send_record(input qid_t q, input logic [15:0] sz, input int max_wait);
        int   waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        @(posedge pcie_clk);
        in_valid <= 1'b1;
        in_pkt_queue_id <= q;
        in_size <= sz;
        while (!taken && waited < max_wait) begin
            @(posedge pcie_clk);
            waited++;
            taken = in_ready;
        end
        in_valid <= 1'b0;
        if (!taken) begin
            report_failure($sformatf("record for queue %0d not accepted in %0d cycles",
                                     q, max_wait));
        end
    endtask

    // random records and back-pressure, software frees each consumed slot
    task run_traffic(input int nb_records, input int max_cycles);
        int                                 sent;
        int                                 taken;
        int                                 drained;
        int                                 cyc;
        logic [`FLOW_ID_WIDTH+`RB_AWIDTH:0] upd;
        sent = 0;
        taken = 0;
        drained = 0;
        cyc = 0;
        while ((taken < nb_records || drained < nb_records || head_q.size() != 0)
               && cyc < max_cycles) begin
            @(posedge pcie_clk);
            cyc++;
            if (in_valid && in_ready) begin
                taken++;
            end
            if (out_valid && out_ready) begin
                drained++;
                head_q.push_back({out_pkt_queue_id, next_slot(out_slot, rb_cfg)});
            end
            if (!in_valid || in_ready) begin
                if (sent < nb_records && ($random(seed) & 3) != 0) begin
                    in_valid <= 1'b1;
                    in_pkt_queue_id <= qid_t'($random(seed));
                    in_size <= 16'($random(seed));
                    sent++;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= (sent < nb_records) ? 1'($random(seed)) : 1'b1;
            if (head_q.size() != 0) begin
                upd = head_q.pop_front();
                mmio_write <= 1'b1;
                mmio_address <= queue_addr(upd[`FLOW_ID_WIDTH+`RB_AWIDTH:`RB_AWIDTH+1]);
                mmio_writedata <= 32'(upd[`RB_AWIDTH:0]);
            end else begin
                mmio_write <= 1'b0;
            end
        end
        in_valid <= 1'b0;
        mmio_write <= 1'b0;
        if (taken < nb_records || drained < nb_records || head_q.size() != 0) begin
            report_failure($sformatf("traffic stuck after %0d cycles, %0d in, %0d out",
                                     cyc, taken, drained));
        end
    endtask

    initial begin
        in_valid = 1'b0;
        in_pkt_queue_id = '0;
        in_size = '0;
        out_ready = 1'b0;
        mmio_address = '0;
        mmio_write = 1'b0;
        mmio_read = 1'b0;
        mmio_writedata = '0;
        rb_cfg = '0;
        @(posedge rst_n);
        repeat (4) @(posedge pcie_clk);
        out_ready <= 1'b1;

        // ring of 4 holds 3 records per queue
        rb_cfg = 4;
        mmio_write_word(16'h0000, ctrl_word(1'b0, rb_cfg, 1'b0));
        mmio_read_word(16'h0000);
        mmio_read_word(16'h0008);
        for (int i = 0; i < 3; i++) begin
            send_record(5, 16'h0100 + 16'(i), 20);
        end
        // fourth record waits until software frees slot 0
        fork
            send_record(5, 16'h0103, 40);
            begin
                repeat (8) @(posedge pcie_clk);
                mmio_write_word(queue_addr(5), 32'd1);
            end
        join

        // disabled block holds the record back
        mmio_write_word(16'h0000, ctrl_word(1'b1, rb_cfg, 1'b0));
        mmio_read_word(16'h0000);
        fork
            send_record(2, 16'h0200, 40);
            begin
                repeat (6) @(posedge pcie_clk);
                mmio_write_word(16'h0000, ctrl_word(1'b0, rb_cfg, 1'b0));
            end
        join

        // soft reset, queue 2 restarts at slot 0
        mmio_write_word(16'h0000, ctrl_word(1'b0, rb_cfg, 1'b1));
        fork
            send_record(2, 16'h0201, 40);
            begin
                repeat (6) @(posedge pcie_clk);
                mmio_write_word(16'h0000, ctrl_word(1'b0, rb_cfg, 1'b0));
            end
        join

        rb_cfg = 8;
        mmio_write_word(16'h0000, ctrl_word(1'b0, rb_cfg, 1'b1));
        mmio_write_word(16'h0000, ctrl_word(1'b0, rb_cfg, 1'b0));
        run_traffic(250, 1500);
        mmio_read_word(16'h0000);
        repeat (4) @(posedge pcie_clk);

        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d accepted records never came out", exp_q.size()));
        end
        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (stim_cycles * 4) @(posedge pcie_clk);
        other_errors++;
        $display("timeout: run did not end within %0d clock cycles", stim_cycles * 4);
        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: pcie_qm.f
+incdir+logic
logic/mmio_pkg.sv
logic/queue_pkg.sv
logic/mmio_regs.sv
logic/meta_dispatch.sv
logic/pkt_queue_manager.sv
logic/ordered_merge.sv
logic/pcie_qm_top.sv
tests/tb_clock.sv
tests/pcie_qm_tb.sv
